// ==== include/leaf_macros.svh ====
`ifndef LEAF_MACROS_SVH
`define LEAF_MACROS_SVH

// network word fields, msb first: vld, dst_leaf, dst_port, body
`define LEAF_PACKET_BITS 49
`define LEAF_ID_BITS 5
`define LEAF_PORT_BITS 4
// body of a data packet
`define LEAF_ADDR_BITS 7
`define LEAF_PAYLOAD_BITS 32
// whatever is left after the header fields
`define LEAF_BODY_BITS (`LEAF_PACKET_BITS - 1 - `LEAF_ID_BITS - `LEAF_PORT_BITS)

// receive FIFO entries, power of two
`define LEAF_RX_DEPTH 4

// dst_port meaning on a leaf
`define LEAF_CFG_PORT 0
`define LEAF_DATA_PORT 1

// leaf numbers of the two pages
`define PAGE0_LEAF 2
`define PAGE1_LEAF 3

`endif

// ==== hdl/leaf_pkg.sv ====
`default_nettype none

package leaf_pkg;

  `include "leaf_macros.svh"

  // data view of the body
  typedef struct packed {
    logic [`LEAF_ADDR_BITS-1:0]    addr;
    logic [`LEAF_PAYLOAD_BITS-1:0] payload;
  } body_data_t;

  // config view, sets the return route of the page
  typedef struct packed {
    logic [`LEAF_ID_BITS-1:0]   ret_leaf;
    logic [`LEAF_PORT_BITS-1:0] ret_port;
    // clears the kernel state
    logic                       clear;
    logic [`LEAF_BODY_BITS-`LEAF_ID_BITS-`LEAF_PORT_BITS-2:0] rsvd;
  } body_cfg_t;

  // dst_port picks which view applies
  typedef union packed {
    body_data_t data;
    body_cfg_t  cfg;
  } packet_body_u;

  // network word, same format both directions
  typedef struct packed {
    logic                       vld;
    logic [`LEAF_ID_BITS-1:0]   dst_leaf;
    logic [`LEAF_PORT_BITS-1:0] dst_port;
    packet_body_u               body;
  } leaf_packet_t;

  // beat on the kernel streams
  typedef struct packed {
    logic [`LEAF_ADDR_BITS-1:0]    addr;
    logic [`LEAF_PAYLOAD_BITS-1:0] data;
  } stream_beat_t;

  typedef struct packed {
    logic [`LEAF_ID_BITS-1:0]   leaf;
    logic [`LEAF_PORT_BITS-1:0] port;
  } route_t;

endpackage

`default_nettype wire

// ==== hdl/leaf_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "leaf_macros.svh"

module leaf_rx
  import leaf_pkg::*;
#(
  parameter int LEAF_ID = 0
) (
  input  logic         clk_400_0,
  input  logic         reset_400_0,
  input  leaf_packet_t pkt,
  output stream_beat_t beat,
  output logic         beat_vld,
  input  logic         beat_ack,
  output route_t       route,
  output logic         clear
);

  localparam int PTR_BITS = $clog2(`LEAF_RX_DEPTH);
  localparam logic [`LEAF_PORT_BITS-1:0] CFG_PORT = `LEAF_CFG_PORT;
  localparam logic [`LEAF_PORT_BITS-1:0] DATA_PORT = `LEAF_DATA_PORT;

  stream_beat_t        mem [`LEAF_RX_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;
  logic                hit;
  logic                cfg_hit;
  logic                data_hit;
  logic                full;
  logic                wr_en;
  logic                rd_en;

  // only valid words for this leaf
  assign hit = pkt.vld && (pkt.dst_leaf == LEAF_ID[`LEAF_ID_BITS-1:0]);
  assign cfg_hit = hit && (pkt.dst_port == CFG_PORT);
  assign data_hit = hit && (pkt.dst_port == DATA_PORT);

  assign full = (count == `LEAF_RX_DEPTH);
  // full FIFO drops the packet
  assign wr_en = data_hit && !full;
  assign rd_en = beat_vld && beat_ack;

  // head of FIFO
  assign beat = mem[rd_ptr];
  assign beat_vld = (count != '0);

  always_ff @(posedge clk_400_0) begin
    if (reset_400_0) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      route <= '0;
      clear <= 1'b0;
    end else begin
      // pointers wrap on their own
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !rd_en) count <= count + 1'b1;
      else if (rd_en && !wr_en) count <= count - 1'b1;
      // config word sets return route
      if (cfg_hit) begin
        route.leaf <= pkt.body.cfg.ret_leaf;
        route.port <= pkt.body.cfg.ret_port;
      end
      // one cycle pulse
      clear <= cfg_hit && pkt.body.cfg.clear;
    end
  end

  // body of a data word becomes the beat
  always_ff @(posedge clk_400_0) begin
    if (wr_en) begin
      mem[wr_ptr].addr <= pkt.body.data.addr;
      mem[wr_ptr].data <= pkt.body.data.payload;
    end
  end

  a_no_drop: assert property (@(posedge clk_400_0) disable iff (reset_400_0)
    data_hit |-> !full)
    else $error("leaf_rx %0d: data packet dropped, FIFO full", LEAF_ID);

  a_beat_stable: assert property (@(posedge clk_400_0) disable iff (reset_400_0)
    beat_vld && !beat_ack |=> beat_vld && $stable(beat));

endmodule

`default_nettype wire

// ==== hdl/leaf_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_tx
  import leaf_pkg::*;
(
  input  logic         clk_400_0,
  input  logic         reset_400_0,
  input  stream_beat_t beat,
  input  logic         beat_vld,
  output logic         beat_ack,
  input  logic         hold,
  input  route_t       route,
  output leaf_packet_t pkt
);

  // no network back-pressure, only hold stalls us
  assign beat_ack = !hold;

  always_ff @(posedge clk_400_0) begin
    if (reset_400_0) begin
      pkt.vld <= 1'b0;
    end else begin
      // idle cycles send vld 0
      pkt.vld <= beat_vld && !hold;
    end
    // header follows the current return route
    pkt.dst_leaf <= route.leaf;
    pkt.dst_port <= route.port;
    // result rides in the data view
    pkt.body.data.addr <= beat.addr;
    pkt.body.data.payload <= beat.data;
  end

endmodule

`default_nettype wire

// ==== hdl/leaf_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module leaf_interface
  import leaf_pkg::*;
#(
  parameter int LEAF_ID = 0
) (
  input  logic         clk_400_0,
  input  logic         reset_400_0,
  input  leaf_packet_t din,
  output leaf_packet_t dout,
  input  logic         resend,
  output stream_beat_t to_user,
  output logic         to_user_vld,
  input  logic         to_user_ack,
  input  stream_beat_t from_user,
  input  logic         from_user_vld,
  output logic         from_user_ack,
  output logic         clear
);

  leaf_packet_t rx_pkt;
  leaf_packet_t tx_pkt;
  leaf_packet_t echo;
  logic         resend_q;
  route_t       route;

  // nothing enters from the network during resend
  always_comb begin
    rx_pkt = din;
    rx_pkt.vld = din.vld && !resend;
  end

  // echo path, din one cycle late
  always_ff @(posedge clk_400_0) begin
    if (resend) echo <= din;
  end

  always_ff @(posedge clk_400_0) begin
    if (reset_400_0) resend_q <= 1'b0;
    else resend_q <= resend;
  end

  // echo owns dout while the registered resend is up
  assign dout = resend_q ? echo : tx_pkt;

  leaf_rx #(
    .LEAF_ID (LEAF_ID)
  ) u_rx (
    .clk_400_0   (clk_400_0),
    .reset_400_0 (reset_400_0),
    .pkt         (rx_pkt),
    .beat        (to_user),
    .beat_vld    (to_user_vld),
    .beat_ack    (to_user_ack),
    .route       (route),
    .clear       (clear)
  );

  // tx stalls during resend, results wait in the kernel
  leaf_tx u_tx (
    .clk_400_0   (clk_400_0),
    .reset_400_0 (reset_400_0),
    .beat        (from_user),
    .beat_vld    (from_user_vld),
    .beat_ack    (from_user_ack),
    .hold        (resend),
    .route       (route),
    .pkt         (tx_pkt)
  );

endmodule

`default_nettype wire

// ==== hdl/sum_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "leaf_macros.svh"

module sum_kernel
  import leaf_pkg::*;
(
  input  logic         clk_400_0,
  input  logic         reset_400_0,
  input  logic         clear,
  input  stream_beat_t in_beat,
  input  logic         in_vld,
  output logic         in_ack,
  output stream_beat_t out_beat,
  output logic         out_vld,
  input  logic         out_ack
);

  logic [`LEAF_PAYLOAD_BITS-1:0] sum;
  logic [`LEAF_PAYLOAD_BITS-1:0] sum_next;
  logic                          accept;

  // room when output slot is empty or draining
  assign in_ack = !out_vld || out_ack;
  assign accept = in_vld && in_ack;
  // wraps at 32 bits
  assign sum_next = sum + in_beat.data;

  always_ff @(posedge clk_400_0) begin
    if (reset_400_0) begin
      sum <= '0;
      out_vld <= 1'b0;
    end else begin
      if (clear) sum <= '0;
      else if (accept) sum <= sum_next;
      if (accept) out_vld <= 1'b1;
      else if (out_ack) out_vld <= 1'b0;
    end
  end

  // result keeps the addr of its input
  always_ff @(posedge clk_400_0) begin
    if (accept) begin
      out_beat.addr <= in_beat.addr;
      out_beat.data <= sum_next;
    end
  end

  a_clear_no_beat: assert property (@(posedge clk_400_0) disable iff (reset_400_0)
    clear |-> !accept);

endmodule

`default_nettype wire

// ==== hdl/page_double.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "leaf_macros.svh"

module page_double
  import leaf_pkg::*;
(
  input  logic         clk_400_0,
  input  logic         reset_400_0,
  input  leaf_packet_t din_0,
  input  leaf_packet_t din_1,
  output leaf_packet_t dout_0,
  output leaf_packet_t dout_1,
  input  logic         resend_0,
  input  logic         resend_1
);

  // page 0 streams
  stream_beat_t to_user_0;
  logic         to_user_vld_0;
  logic         to_user_ack_0;
  stream_beat_t from_user_0;
  logic         from_user_vld_0;
  logic         from_user_ack_0;
  logic         clear_0;
  // page 1 streams
  stream_beat_t to_user_1;
  logic         to_user_vld_1;
  logic         to_user_ack_1;
  stream_beat_t from_user_1;
  logic         from_user_vld_1;
  logic         from_user_ack_1;
  logic         clear_1;

  leaf_interface #(
    .LEAF_ID (`PAGE0_LEAF)
  ) u_if_0 (
    .clk_400_0     (clk_400_0),
    .reset_400_0   (reset_400_0),
    .din           (din_0),
    .dout          (dout_0),
    .resend        (resend_0),
    .to_user       (to_user_0),
    .to_user_vld   (to_user_vld_0),
    .to_user_ack   (to_user_ack_0),
    .from_user     (from_user_0),
    .from_user_vld (from_user_vld_0),
    .from_user_ack (from_user_ack_0),
    .clear         (clear_0)
  );

  sum_kernel u_kernel_0 (
    .clk_400_0   (clk_400_0),
    .reset_400_0 (reset_400_0),
    .clear       (clear_0),
    .in_beat     (to_user_0),
    .in_vld      (to_user_vld_0),
    .in_ack      (to_user_ack_0),
    .out_beat    (from_user_0),
    .out_vld     (from_user_vld_0),
    .out_ack     (from_user_ack_0)
  );

  leaf_interface #(
    .LEAF_ID (`PAGE1_LEAF)
  ) u_if_1 (
    .clk_400_0     (clk_400_0),
    .reset_400_0   (reset_400_0),
    .din           (din_1),
    .dout          (dout_1),
    .resend        (resend_1),
    .to_user       (to_user_1),
    .to_user_vld   (to_user_vld_1),
    .to_user_ack   (to_user_ack_1),
    .from_user     (from_user_1),
    .from_user_vld (from_user_vld_1),
    .from_user_ack (from_user_ack_1),
    .clear         (clear_1)
  );

  sum_kernel u_kernel_1 (
    .clk_400_0   (clk_400_0),
    .reset_400_0 (reset_400_0),
    .clear       (clear_1),
    .in_beat     (to_user_1),
    .in_vld      (to_user_vld_1),
    .in_ack      (to_user_ack_1),
    .out_beat    (from_user_1),
    .out_vld     (from_user_vld_1),
    .out_ack     (from_user_ack_1)
  );

endmodule

`default_nettype wire

// ==== sim/page_double_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "leaf_macros.svh"

module page_double_tb
  import leaf_pkg::*;
;

  // stimulus row whose results come from the model
  typedef struct packed {
    logic        page;
    logic        is_data;
    logic [4:0]  dst_leaf;
    logic [6:0]  addr;
    logic [31:0] payload;
    logic [4:0]  ret_leaf;
    logic [3:0]  ret_port;
    logic        clear;
    logic        rnd;
    logic [2:0]  resend;
    logic        expect_out;
  } entry_t;

  logic         clk_400_0;
  logic         reset_400_0;
  leaf_packet_t din_0;
  leaf_packet_t din_1;
  leaf_packet_t dout_0;
  leaf_packet_t dout_1;
  logic         resend_0;
  logic         resend_1;
  entry_t       stim [$];
  integer       seed;
  int           checks;
  int           errors;
  int           tests;
  bit           timed_out;
  // per page model state
  logic [31:0]  sum [2];
  logic [4:0]   route_leaf [2];
  logic [3:0]   route_port [2];

  page_double u_dut (
    .clk_400_0   (clk_400_0),
    .reset_400_0 (reset_400_0),
    .din_0       (din_0),
    .din_1       (din_1),
    .dout_0      (dout_0),
    .dout_1      (dout_1),
    .resend_0    (resend_0),
    .resend_1    (resend_1)
  );

  always #4 clk_400_0 = ~clk_400_0;

  function automatic logic [4:0] page_leaf(input int page);
    return (page != 0) ? 5'(`PAGE1_LEAF) : 5'(`PAGE0_LEAF);
  endfunction

  function automatic leaf_packet_t page_out(input int page);
    return (page != 0) ? dout_1 : dout_0;
  endfunction

  function automatic leaf_packet_t make_packet(input logic is_data, input logic [4:0] leaf,
      input logic [6:0] addr, input logic [31:0] payload, input logic [4:0] ret_leaf,
      input logic [3:0] ret_port, input logic clear);
    leaf_packet_t pkt;
    pkt = '0;
    pkt.vld = 1'b1;
    pkt.dst_leaf = leaf;
    if (is_data) begin
      pkt.dst_port = 4'(`LEAF_DATA_PORT);
      pkt.body.data.addr = addr;
      pkt.body.data.payload = payload;
    end else begin
      pkt.dst_port = 4'(`LEAF_CFG_PORT);
      pkt.body.cfg.ret_leaf = ret_leaf;
      pkt.body.cfg.ret_port = ret_port;
      pkt.body.cfg.clear = clear;
    end
    return pkt;
  endfunction

  // reference page model updates sum and route for words on its own leaf
  task automatic model_apply(input int page, input leaf_packet_t pkt, output leaf_packet_t exp);
    if (pkt.vld && pkt.dst_leaf == page_leaf(page)) begin
      if (pkt.dst_port == 4'(`LEAF_CFG_PORT)) begin
        route_leaf[page] = pkt.body.cfg.ret_leaf;
        route_port[page] = pkt.body.cfg.ret_port;
        if (pkt.body.cfg.clear) sum[page] = '0;
      end else if (pkt.dst_port == 4'(`LEAF_DATA_PORT)) begin
        sum[page] = sum[page] + pkt.body.data.payload;
      end
    end
    exp = '0;
    exp.vld = 1'b1;
    exp.dst_leaf = route_leaf[page];
    exp.dst_port = route_port[page];
    exp.body.data.addr = pkt.body.data.addr;
    exp.body.data.payload = sum[page];
  endtask

  task automatic check_packet(input leaf_packet_t got, input leaf_packet_t exp,
      input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idle(input leaf_packet_t got, input string what);
    checks++;
    if (got.vld !== 1'b0) begin
      errors++;
      $display("MISMATCH @%0t: %s vld %b expected 0", $time, what, got.vld);
    end
  endtask

  // new word and resend level for one page on the next rising edge
  task automatic drive(input int page, input leaf_packet_t word, input logic rs);
    @(posedge clk_400_0);
    if (page == 0) begin
      din_0 <= word;
      resend_0 <= rs;
    end else begin
      din_1 <= word;
      resend_1 <= rs;
    end
  endtask

  task automatic watch_idle(input int page, input int cycles);
    repeat (cycles) begin
      @(negedge clk_400_0);
      check_idle(page_out(page), "idle dout");
    end
  endtask

  // waits for one result per page in need
  // first counts the cycles already gone since din
  task automatic wait_results(input logic [1:0] need, input leaf_packet_t exp0,
      input leaf_packet_t exp1, input int first, input bit check_lat);
    leaf_packet_t got [2];
    logic [1:0]   seen;
    int           elapsed;
    seen = 2'b00;
    elapsed = first;
    while (seen != need && elapsed < 20) begin
      @(negedge clk_400_0);
      got[0] = dout_0;
      got[1] = dout_1;
      for (int p = 0; p < 2; p++) begin
        if (need[p] && !seen[p] && got[p].vld) begin
          seen[p] = 1'b1;
          check_packet(got[p], (p != 0) ? exp1 : exp0, (p != 0) ? "dout_1" : "dout_0");
          if (check_lat && elapsed != 3) begin
            errors++;
            $display("MISMATCH @%0t: page %0d latency %0d expected 3", $time, p, elapsed);
          end
        end
      end
      elapsed++;
    end
    if (seen != need) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: no result from page mask %b within 20 cycles", need & ~seen);
    end
  endtask

  task automatic report(input string name, input int err_start);
    tests++;
    $display("test %0d %s %s", tests, name, (errors == err_start) ? "ok" : "FAIL");
  endtask

  task automatic run_entry(input entry_t e);
    leaf_packet_t pkt;
    leaf_packet_t exp;
    leaf_packet_t prev;
    leaf_packet_t word;
    logic [63:0]  rnd;
    logic [31:0]  payload;
    int           err_start;
    err_start = errors;
    payload = e.rnd ? $random(seed) : e.payload;
    pkt = make_packet(e.is_data, e.dst_leaf, e.addr, payload, e.ret_leaf, e.ret_port,
                      e.clear);
    model_apply(e.page, pkt, exp);
    prev = '0;
    drive(e.page, pkt, 1'b0);
    if (e.resend == 0) begin
      drive(e.page, '0, 1'b0);
      if (e.expect_out) wait_results(2'b01 << e.page, exp, exp, 1, 1'b1);
      else watch_idle(e.page, 5);
    end else begin
      // dout trails din by one cycle while resend is up
      for (int i = 0; i < e.resend; i++) begin
        rnd = {$random(seed), $random(seed)};
        word = rnd[48:0];
        // first word hits this page's data port and must stay out of the sum
        if (i == 0) begin
          word.vld = 1'b1;
          word.dst_leaf = page_leaf(e.page);
          word.dst_port = 4'(`LEAF_DATA_PORT);
        end
        drive(e.page, word, 1'b1);
        @(negedge clk_400_0);
        if (i == 0) check_idle(page_out(e.page), "dout before echo");
        else check_packet(page_out(e.page), prev, "echo");
        prev = word;
      end
      drive(e.page, '0, 1'b0);
      @(negedge clk_400_0);
      check_packet(page_out(e.page), prev, "last echo");
      // held result leaves once resend is down
      wait_results(2'b01 << e.page, exp, exp, 0, 1'b0);
    end
    report(e.is_data ? "data" : "config", err_start);
  endtask

  // both pages at once with different payloads
  task automatic run_dual(input int k);
    leaf_packet_t pkt0;
    leaf_packet_t pkt1;
    leaf_packet_t exp0;
    leaf_packet_t exp1;
    int           err_start;
    err_start = errors;
    pkt0 = make_packet(1'b1, page_leaf(0), 7'(20 + k), $random(seed), '0, '0, 1'b0);
    pkt1 = make_packet(1'b1, page_leaf(1), 7'(40 + k), $random(seed), '0, '0, 1'b0);
    model_apply(0, pkt0, exp0);
    model_apply(1, pkt1, exp1);
    @(posedge clk_400_0);
    din_0 <= pkt0;
    din_1 <= pkt1;
    @(posedge clk_400_0);
    din_0 <= '0;
    din_1 <= '0;
    wait_results(2'b11, exp0, exp1, 1, 1'b1);
    report("dual", err_start);
  endtask

  initial begin
    clk_400_0 = 1'b0;
    reset_400_0 = 1'b1;
    din_0 = '0;
    din_1 = '0;
    resend_0 = 1'b0;
    resend_1 = 1'b0;
    seed = 32'h30f0;
    checks = 0;
    errors = 0;
    tests = 0;
    timed_out = 1'b0;
    for (int p = 0; p < 2; p++) begin
      sum[p] = '0;
      route_leaf[p] = '0;
      route_port[p] = '0;
    end
    // page data leaf addr payload ret_leaf ret_port clear rnd resend expect
    stim.push_back('{1'b0, 1'b0, 5'd2, 7'd0, 32'd0, 5'd7, 4'd5, 1'b0, 1'b0, 3'd0, 1'b0});
    stim.push_back('{1'b0, 1'b1, 5'd2, 7'd1, 32'd10, 5'd0, 4'd0, 1'b0, 1'b0, 3'd0, 1'b1});
    stim.push_back('{1'b0, 1'b1, 5'd2, 7'd2, 32'd0, 5'd0, 4'd0, 1'b0, 1'b1, 3'd0, 1'b1});
    stim.push_back('{1'b0, 1'b1, 5'd3, 7'd3, 32'd99, 5'd0, 4'd0, 1'b0, 1'b0, 3'd0, 1'b0});
    stim.push_back('{1'b0, 1'b1, 5'd2, 7'd4, 32'd5, 5'd0, 4'd0, 1'b0, 1'b0, 3'd0, 1'b1});
    stim.push_back('{1'b1, 1'b0, 5'd3, 7'd0, 32'd0, 5'd9, 4'd2, 1'b0, 1'b0, 3'd0, 1'b0});
    stim.push_back('{1'b1, 1'b1, 5'd3, 7'd8, 32'd1000, 5'd0, 4'd0, 1'b0, 1'b0, 3'd0, 1'b1});
    stim.push_back('{1'b0, 1'b0, 5'd2, 7'd0, 32'd0, 5'd7, 4'd6, 1'b1, 1'b0, 3'd0, 1'b0});
    stim.push_back('{1'b0, 1'b1, 5'd2, 7'd9, 32'd42, 5'd0, 4'd0, 1'b0, 1'b0, 3'd0, 1'b1});
    stim.push_back('{1'b0, 1'b1, 5'd2, 7'd10, 32'd0, 5'd0, 4'd0, 1'b0, 1'b1, 3'd3, 1'b1});
    stim.push_back('{1'b1, 1'b1, 5'd2, 7'd5, 32'd77, 5'd0, 4'd0, 1'b0, 1'b0, 3'd0, 1'b0});
    stim.push_back('{1'b1, 1'b1, 5'd3, 7'd11, 32'd0, 5'd0, 4'd0, 1'b0, 1'b1, 3'd2, 1'b1});
    stim.push_back('{1'b0, 1'b1, 5'd2, 7'd12, 32'd1, 5'd0, 4'd0, 1'b0, 1'b0, 3'd0, 1'b1});
    repeat (4) @(posedge clk_400_0);
    reset_400_0 <= 1'b0;
    // quiet network after reset
    repeat (4) begin
      @(negedge clk_400_0);
      check_idle(dout_0, "dout_0 after reset");
      check_idle(dout_1, "dout_1 after reset");
    end
    report("reset", 0);
    for (int i = 0; i < stim.size() && !timed_out; i++) run_entry(stim[i]);
    for (int k = 0; k < 3 && !timed_out; k++) run_dual(k);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && !timed_out) $display("All checks passed");
    else $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
hdl/leaf_pkg.sv
hdl/leaf_rx.sv
hdl/leaf_tx.sv
hdl/leaf_interface.sv
hdl/sum_kernel.sv
hdl/page_double.sv
sim/page_double_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module page_double_tb -o sim_page_double

run: compile
	./obj_dir/sim_page_double | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
